//--- source/execPkg.sv
//--------------------------------------------------
// Shared definitions of the integer execute stage.
// Widths, field types, opcode constants, the unit
// class encoding and the status word bit layout.
// Modules take it by a wildcard import.
//--------------------------------------------------
package execPkg;

   localparam int DataWidth = 32;            // Data path width

   typedef logic [DataWidth-1:0] Word;       // Operands and results
   typedef logic [5:0]           Opcode;
   typedef logic [15:0]          Imm;
   typedef logic [4:0]           RegNum;

   // Which execute unit owns the operation
   typedef enum logic [1:0] {
      ClassAdd    = 2'd0,                    // Adder family
      ClassBarrel = 2'd1,                    // Barrel shifter
      ClassSlm    = 2'd2                     // Shift, logic, move
   } UnitClass;

   localparam Opcode OpMove    = 6'o45;      // MFS/MTS and friends
   localparam Opcode OpReturn  = 6'o55;
   localparam Opcode OpBreakA  = 6'o56;
   localparam Opcode OpBreakB  = 6'o66;      // Immediate form
   localparam RegNum RegBreak  = 5'd12;      // RA of a break
   localparam RegNum RegIntr   = 5'd14;      // RA of an interrupt

   // Status word bits
   localparam int MsrBe  = 0;                // Bus lock
   localparam int MsrIe  = 1;                // Interrupt enable
   localparam int MsrC   = 2;                // Carry
   localparam int MsrBip = 3;                // Break in progress
   localparam int MsrTxe = 8;                // Threads enabled
   localparam int MsrPha = 9;                // Current phase
   localparam int MsrHte = 10;               // Hardware threads
   localparam int MsrCc  = 31;               // Carry copy

   // Immediate field bits
   localparam int ImmMts    = 14;            // Set for MTS, clear for MFS
   localparam int ImmCmpUns = 1;             // Unsigned compare
   localparam int ImmCmpSel = 0;             // Compare instead of subtract

endpackage

//--- source/execOpIf.sv
//--------------------------------------------------
// One decoded operation as the execute stage sees
// it. The top level fills it from its ports and
// both the arithmetic unit and the status logic
// read it.
//--------------------------------------------------
`timescale 1ns/10ps

interface execOpIf
   import execPkg::*;
();
   Opcode    opcode;
   UnitClass unitClass;
   Imm       imm;
   RegNum    ra;        // Source register number
   RegNum    rd;        // Destination register number
   Word      opA;
   Word      opB;       // RB or immediate

   modport driver (output opcode, unitClass, imm, ra, rd, opA, opB);
   modport reader (input opcode, unitClass, imm, ra, rd, opA, opB);

endinterface

//--- source/arithUnit.sv
//--------------------------------------------------
// Combinational datapath of the execute stage.
// Adder and comparator, logic ops, one-bit shifts,
// moves and the barrel shifter. Results go to the
// result stage, the adder carry to the flags.
//--------------------------------------------------
`timescale 1ns/10ps

module arithUnit
   import execPkg::*;
#(
   parameter bit BarrelEnable = 1'b1   // Build the barrel shifter
) (
   execOpIf.reader op,
   input  logic carry_i,               // Carry of the current phase
   output Word  resAdd_o,
   output logic addCarry_o,
   output Word  resBarrel_o,
   output Word  resShiftLogic_o,
   input  Word  msrWord_i              // Status word image for MFS
);

   logic               addFamily;
   logic               carryIn;
   Word                addA;
   logic [DataWidth:0] sum;            // Bit 32 is the carry out
   logic               cmpSel;
   logic               cmpGt;
   logic               isMfs;
   Word                shiftOne;
   Word                moveRes;
   Word                barrelRaw;
   logic [4:0]         shAmt;

   // Adder: B + (~)A + cin
   assign addFamily = (op.opcode[5:4] == 2'b00);
   assign addA      = (addFamily & op.opcode[0]) ? ~op.opA : op.opA;   // Reverse subtract
   assign carryIn   = addFamily & (op.opcode[1] ? carry_i : op.opcode[0]);
   assign sum       = {1'b0, op.opB} + {1'b0, addA} + {{DataWidth{1'b0}}, carryIn};

   // CMP and CMPU share the RSUB opcode
   assign cmpSel = (op.opcode == 6'o05) & op.imm[ImmCmpSel];
   assign cmpGt  = op.imm[ImmCmpUns] ? (op.opA > op.opB)
                                     : ($signed(op.opA) > $signed(op.opB));

   assign resAdd_o   = cmpSel ? {cmpGt, sum[DataWidth-2:0]} : sum[DataWidth-1:0];
   assign addCarry_o = sum[DataWidth];

   // One-bit right shifts and sign extension
   always_comb begin
      case (op.imm[6:5])
         2'd0: shiftOne = {op.opA[DataWidth-1], op.opA[DataWidth-1:1]};  // SRA
         2'd1: shiftOne = {carry_i, op.opA[DataWidth-1:1]};             // SRC
         2'd2: shiftOne = {1'b0, op.opA[DataWidth-1:1]};                // SRL
         default: shiftOne = op.imm[0] ? {{16{op.opA[15]}}, op.opA[15:0]}
                                       : {{24{op.opA[7]}}, op.opA[7:0]};
      endcase
   end

   // Moves
   assign isMfs = (op.opcode == OpMove) & ~op.imm[ImmMts] & op.imm[0];

   always_comb begin
      if (isMfs)
         moveRes = msrWord_i;          // MFS rmsr
      else if (op.ra[3])
         moveRes = op.opB;             // Branch target
      else
         moveRes = op.opA;             // MFS rpc
   end

   always_comb begin
      case (op.opcode[2:0])
         3'd0: resShiftLogic_o = op.opA | op.opB;
         3'd1: resShiftLogic_o = op.opA & op.opB;
         3'd2: resShiftLogic_o = op.opA ^ op.opB;
         3'd3: resShiftLogic_o = op.opA & ~op.opB;   // ANDN
         3'd4: resShiftLogic_o = shiftOne;
         3'd5: resShiftLogic_o = moveRes;
         3'd6: resShiftLogic_o = op.opB;
         default: resShiftLogic_o = '0;
      endcase
   end

   // Barrel shifter, amount from B
   assign shAmt = op.opB[4:0];

   always_comb begin
      case (op.imm[10:9])
         2'd0: barrelRaw = op.opA >> shAmt;
         2'd1: barrelRaw = Word'($signed(op.opA) >>> shAmt);
         2'd2: barrelRaw = op.opA << shAmt;
         default: barrelRaw = '0;
      endcase
   end

   assign resBarrel_o = BarrelEnable ? barrelRaw : '0;

   // Decoder never issues barrel mode 3
   always_comb begin
      if (op.unitClass == ClassBarrel) begin
         assert final (op.imm[10:9] != 2'b11)
            else $error("barrel shifter issued with undefined mode");
      end
   end

endmodule

//--- source/statusRegs.sv
//--------------------------------------------------
// Machine status flags of the execute stage.
// Holds one carry bank per thread phase plus the
// IE, BIP and BE flags, updated on return, break,
// interrupt and MTS. Also builds the status word.
//--------------------------------------------------
`timescale 1ns/10ps

module statusRegs
   import execPkg::*;
#(
   parameter bit ThreadsEnable = 1'b1
) (
   input  logic clk_i,
   input  logic rst_i,
   input  logic ena_i,               // Stall when low
   input  logic pha_i,               // Thread phase
   execOpIf.reader op,
   input  logic addCarry_i,
   output logic carry_o,             // Carry of the current phase
   output Word  msrWord_o,
   output logic msrIe_o,
   output logic msrBip_o,
   output logic msrBe_o
);

   logic carry0;                     // Phase 0 bank
   logic carry1;                     // Phase 1 bank
   logic carryNext;
   logic isMts;
   logic isReturn;
   logic isBreak;

   assign carry_o  = pha_i ? carry1 : carry0;
   assign isMts    = (op.opcode == OpMove) & op.imm[ImmMts];
   assign isReturn = (op.opcode == OpReturn);
   assign isBreak  = (op.opcode == OpBreakA) | (op.opcode == OpBreakB);

   // New carry for the bank of this phase
   always_comb begin
      carryNext = carry_o;           // Hold by default
      if (op.unitClass == ClassAdd) begin
         if (!op.opcode[2])
            carryNext = addCarry_i;  // ADD/RSUB family
      end else if (op.unitClass == ClassSlm) begin
         if (isMts)
            carryNext = op.opA[MsrC];
         else if (op.opcode[2:0] == 3'd4 && op.imm[6:5] != 2'b11)
            carryNext = op.opA[0];   // Bit shifted out
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         carry0   <= 1'b0;
         carry1   <= 1'b0;
         msrIe_o  <= 1'b0;
         msrBip_o <= 1'b0;
         msrBe_o  <= 1'b0;
      end else if (ena_i) begin
         if (pha_i)
            carry1 <= carryNext;
         else
            carry0 <= carryNext;

         if (isBreak && op.ra == RegIntr)
            msrIe_o <= 1'b0;         // Interrupt taken
         else if (isReturn && op.rd[0])
            msrIe_o <= 1'b1;         // RTID
         else if (isMts)
            msrIe_o <= op.opA[MsrIe];

         if (isBreak && op.ra == RegBreak)
            msrBip_o <= 1'b1;
         else if (isReturn && op.rd[1])
            msrBip_o <= 1'b0;        // RTBD
         else if (isMts)
            msrBip_o <= op.opA[MsrBip];

         if (isMts)
            msrBe_o <= op.opA[MsrBe];
      end
   end

   // Status word image, unused bits read zero
   always_comb begin
      msrWord_o         = '0;
      msrWord_o[MsrCc]  = carry_o;
      msrWord_o[MsrHte] = ThreadsEnable;
      msrWord_o[MsrPha] = pha_i;
      msrWord_o[MsrTxe] = ThreadsEnable;
      msrWord_o[MsrBip] = msrBip_o;
      msrWord_o[MsrC]   = carry_o;
      msrWord_o[MsrIe]  = msrIe_o;
      msrWord_o[MsrBe]  = msrBe_o;
   end

   // Phase input and flags must stay defined once out of reset
   assert property (@(posedge clk_i) disable iff (rst_i) !$isunknown(msrWord_o))
      else $error("status word has unknown bits");

endmodule

//--- source/resultStage.sv
//--------------------------------------------------
// Result registers of the execute stage. Picks the
// unit result by class into the execute result and
// moves the previous one on to the memory stage.
//--------------------------------------------------
`timescale 1ns/10ps

module resultStage
   import execPkg::*;
(
   input  logic     clk_i,
   input  logic     rst_i,
   input  logic     ena_i,
   input  UnitClass unitClass_i,
   input  Word      resAdd_i,
   input  Word      resBarrel_i,
   input  Word      resShiftLogic_i,
   output Word      resEx_o,         // Execute stage result
   output Word      resMa_o          // Memory stage result
);

   Word resSel;

   always_comb begin
      case (unitClass_i)
         ClassAdd:    resSel = resAdd_i;
         ClassBarrel: resSel = resBarrel_i;
         ClassSlm:    resSel = resShiftLogic_i;
         default:     resSel = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         resEx_o <= '0;
         resMa_o <= '0;
      end else if (ena_i) begin
         resEx_o <= resSel;
         resMa_o <= resEx_o;         // One stage later
      end
   end

   // Decode only issues the three defined classes
   assert property (@(posedge clk_i) disable iff (rst_i)
      ena_i |-> unitClass_i inside {ClassAdd, ClassBarrel, ClassSlm})
      else $error("undefined unit class issued");

endmodule

//--- source/execUnit.sv
//--------------------------------------------------
// Integer execute stage, top level. Packs the
// decoded operation into the operation bus and
// connects the datapath, the status flags and the
// result registers. Results appear one enabled
// clock later on resEx_o, two on resMa_o.
//--------------------------------------------------
`timescale 1ns/10ps

module execUnit
   import execPkg::*;
#(
   parameter bit BarrelEnable  = 1'b1,
   parameter bit ThreadsEnable = 1'b1
) (
   input  logic     clk_i,
   input  logic     rst_i,
   input  logic     ena_i,           // Pipeline enable
   input  logic     pha_i,           // Thread phase
   input  Opcode    opcode_i,
   input  UnitClass unitClass_i,
   input  Imm       imm_i,
   input  RegNum    ra_i,
   input  RegNum    rd_i,
   input  Word      opA_i,
   input  Word      opB_i,
   output Word      resEx_o,
   output Word      resMa_o,
   output logic     msrIe_o,
   output logic     msrBip_o,
   output logic     msrBe_o
);

   logic carry;                      // Current phase carry
   logic addCarry;
   Word  resAdd;
   Word  resBarrel;
   Word  resShiftLogic;
   Word  msrWord;

   execOpIf opIf ();

   assign opIf.opcode    = opcode_i;
   assign opIf.unitClass = unitClass_i;
   assign opIf.imm       = imm_i;
   assign opIf.ra        = ra_i;
   assign opIf.rd        = rd_i;
   assign opIf.opA       = opA_i;
   assign opIf.opB       = opB_i;

   arithUnit #(.BarrelEnable(BarrelEnable)) arith0 (
      .op              (opIf.reader),
      .carry_i         (carry),
      .resAdd_o        (resAdd),
      .addCarry_o      (addCarry),
      .resBarrel_o     (resBarrel),
      .resShiftLogic_o (resShiftLogic),
      .msrWord_i       (msrWord)
   );

   statusRegs #(.ThreadsEnable(ThreadsEnable)) status0 (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ena_i      (ena_i),
      .pha_i      (pha_i),
      .op         (opIf.reader),
      .addCarry_i (addCarry),
      .carry_o    (carry),
      .msrWord_o  (msrWord),
      .msrIe_o    (msrIe_o),
      .msrBip_o   (msrBip_o),
      .msrBe_o    (msrBe_o)
   );

   resultStage result0 (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .ena_i           (ena_i),
      .unitClass_i     (opIf.unitClass),
      .resAdd_i        (resAdd),
      .resBarrel_i     (resBarrel),
      .resShiftLogic_i (resShiftLogic),
      .resEx_o         (resEx_o),
      .resMa_o         (resMa_o)
   );

endmodule

//--- bench/execTb.sv
//--------------------------------------------------
// Directed testbench of the integer execute stage.
// Runs adder, logic, shift, barrel, compare, carry
// bank, status flag and stall tests against models
// of the opcode rules. Operands come from an LFSR.
//--------------------------------------------------
`timescale 1ns/10ps

module execTb
   import execPkg::*;
();

   logic     clk;
   logic     rst;
   logic     ena;
   logic     pha;
   Opcode    opcode;
   UnitClass unitClass;
   Imm       imm;
   RegNum    ra;
   RegNum    rd;
   Word      opA;
   Word      opB;
   Word      resEx;
   Word      resMa;
   logic     msrIe;
   logic     msrBip;
   logic     msrBe;

   int         edgeCount = 0;      // Rising edges seen so far
   logic [31:0] lfsr;
   logic       carryModel [2];     // Expected carry per phase
   logic       ieModel;
   logic       bipModel;
   logic       beModel;
   Word        lastEx;             // Expected resEx_o of the last op

   execUnit #(.BarrelEnable(1'b1), .ThreadsEnable(1'b1)) dut0 (
      .clk_i(clk), .rst_i(rst), .ena_i(ena), .pha_i(pha),
      .opcode_i(opcode), .unitClass_i(unitClass), .imm_i(imm),
      .ra_i(ra), .rd_i(rd), .opA_i(opA), .opB_i(opB),
      .resEx_o(resEx), .resMa_o(resMa),
      .msrIe_o(msrIe), .msrBip_o(msrBip), .msrBe_o(msrBe)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;       // 8 ns period
   end

   always @(posedge clk) edgeCount++;

   // Galois LFSR stepped once per bit taken
   function automatic logic lfsrBit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out)
         lfsr ^= 32'h8020_0003;
      return out;
   endfunction

   function automatic Word randWord();
      Word w;
      int  i;
      w = '0;
      for (i = 0; i < 32; i++)
         w = {w[30:0], lfsrBit()};
      return w;
   endfunction

   // Expected status word from the flag models
   function automatic Word msrImage();
      Word w;
      w         = '0;
      w[MsrCc]  = carryModel[pha];
      w[MsrC]   = carryModel[pha];
      w[MsrTxe] = 1'b1;
      w[MsrHte] = 1'b1;
      w[MsrPha] = pha;
      w[MsrBe]  = beModel;
      w[MsrIe]  = ieModel;
      w[MsrBip] = bipModel;
      return w;
   endfunction

   task automatic checkWord(input string name, input Word got, input Word exp);
      if (got !== exp) begin
         $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "result mismatch");
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at %0d ns: flag %s is %b, expected %b", $time, name, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic compareAllFlags();
      checkFlag("IE", msrIe, ieModel);
      checkFlag("BIP", msrBip, bipModel);
      checkFlag("BE", msrBe, beModel);
   endtask

   // Polls half a ns off the edges and returns 1 ns after the last edge
   task automatic waitEdges(input int n);
      int target;
      int polls;
      target = edgeCount + n;
      polls  = 0;
      #0.5;
      while (edgeCount < target && polls < n * 8 + 4) begin
         #1;
         polls++;
      end
      if (edgeCount < target) begin
         $display("Timeout: the clock stopped before %0d edges had passed", n);
         $display("=== FAIL ===");
         $fatal(1, "clock timeout");
      end
      #0.5;
   endtask

   // One enabled cycle then resEx_o and the shifted resMa_o
   task automatic runOp(input Opcode opc, input UnitClass cls, input Imm im,
                        input RegNum raN, input RegNum rdN,
                        input Word a, input Word b, input Word exp);
      opcode    = opc;
      unitClass = cls;
      imm       = im;
      ra        = raN;
      rd        = rdN;
      opA       = a;
      opB       = b;
      ena       = 1'b1;
      waitEdges(1);
      checkWord("resMa", resMa, lastEx);
      checkWord("resEx", resEx, exp);
      lastEx = exp;
   endtask

   task automatic adderSequence();
      Word          a;
      Word          b;
      logic [32:0]  s;
      logic         cin;
      logic [1:0]   code;
      int           k;
      pha = 1'b0;
      for (k = 0; k < 16; k++) begin
         a    = randWord();
         b    = randWord();
         code = 2'(k);
         cin  = code[1] ? carryModel[0] : code[0];   // Stored carry or RSUB one
         s    = {1'b0, b} + {1'b0, (code[0] ? ~a : a)} + 33'(cin);
         runOp(Opcode'(code), ClassAdd, '0, '0, '0, a, b, s[31:0]);
         carryModel[0] = s[32];
      end
   endtask

   task automatic logicAndShifts();
      Word        a;
      Word        b;
      Word        exp;
      Imm         im;
      int         k;
      logic [1:0] mode;
      for (k = 0; k < 4; k++) begin
         a = randWord();
         b = randWord();
         case (k)
            0: exp = a | b;
            1: exp = a & b;
            2: exp = a ^ b;
            default: exp = a & ~b;
         endcase
         runOp(Opcode'(6'o40 + k), ClassSlm, '0, '0, '0, a, b, exp);
      end
      for (k = 0; k < 10; k++) begin
         a    = randWord();
         mode = (k % 5 > 3) ? 2'd3 : 2'(k % 5);
         im   = '0;
         im[6:5] = mode;
         im[0]   = (k % 5 == 4);   // 16-bit sign extension
         case (mode)
            2'd0: exp = {a[31], a[31:1]};
            2'd1: exp = {carryModel[pha], a[31:1]};
            2'd2: exp = {1'b0, a[31:1]};
            default: exp = im[0] ? {{16{a[15]}}, a[15:0]} : {{24{a[7]}}, a[7:0]};
         endcase
         runOp(6'o44, ClassSlm, im, '0, '0, a, randWord(), exp);
         if (mode != 2'd3)
            carryModel[pha] = a[0];
      end
   endtask

   task automatic barrelSweep();
      Word a;
      Word b;
      Word exp;
      Imm  im;
      int  mode;
      int  amt;
      for (mode = 0; mode < 3; mode++) begin
         for (amt = 0; amt < 32; amt++) begin
            a       = randWord();
            b       = randWord();
            b[4:0]  = 5'(amt);
            im      = '0;
            im[10:9] = 2'(mode);
            case (mode)
               0: exp = a >> amt;
               1: exp = a[31] ? ~((~a) >> amt) : a >> amt;   // Sign fill
               default: exp = a << amt;
            endcase
            runOp(6'o21, ClassBarrel, im, '0, '0, a, b, exp);
         end
      end
   endtask

   // Sign bits differ so signed and unsigned order disagree
   task automatic mixedSignCompare();
      Word  a;
      Word  b;
      Word  diff;
      Imm   im;
      logic gt;
      int   k;
      for (k = 0; k < 8; k++) begin
         a     = randWord();
         b     = randWord();
         a[31] = ~k[1];
         b[31] = k[1];
         im    = '0;
         im[ImmCmpSel] = 1'b1;
         im[ImmCmpUns] = k[0];
         diff  = b - a;
         gt    = k[0] ? a[31] : ~a[31];
         runOp(6'o05, ClassAdd, im, '0, '0, a, b, {gt, diff[30:0]});
      end
   endtask

   task automatic carryPerPhase();
      pha = 1'b0;
      runOp(6'o00, ClassAdd, '0, '0, '0, 32'hFFFF_FFFF, 32'h1, 32'h0);
      carryModel[0] = 1'b1;
      pha = 1'b1;
      runOp(6'o00, ClassAdd, '0, '0, '0, 32'h0, 32'h0, 32'h0);
      carryModel[1] = 1'b0;
      runOp(6'o02, ClassAdd, '0, '0, '0, 32'h0, 32'h0, 32'h0);   // ADDC sees phase 1 carry
      pha = 1'b0;
      runOp(6'o02, ClassAdd, '0, '0, '0, 32'h0, 32'h0, 32'h1);   // Phase 0 carry kept
      carryModel[0] = 1'b0;
   endtask

   task automatic mtsOp(input Word v);
      Imm im;
      im = '0;
      im[ImmMts] = 1'b1;
      runOp(OpMove, ClassSlm, im, '0, '0, v, randWord(), v);
      carryModel[pha] = v[MsrC];
      beModel  = v[MsrBe];
      ieModel  = v[MsrIe];
      bipModel = v[MsrBip];
      compareAllFlags();
   endtask

   task automatic mfsOp();
      runOp(OpMove, ClassSlm, 16'h0001, '0, '0, randWord(), randWord(), msrImage());
   endtask

   task automatic flagEvents();
      Word a;
      Word b;
      a = randWord();
      b = randWord();
      mtsOp(32'h0000_000F);
      mfsOp();
      mtsOp(32'h0);
      mfsOp();
      runOp(OpBreakA, ClassSlm, '0, RegBreak, '0, a, b, b);   // Break
      bipModel = 1'b1;
      compareAllFlags();
      runOp(OpReturn, ClassSlm, '0, '0, 5'd2, a, b, a);       // RTBD
      bipModel = 1'b0;
      compareAllFlags();
      mtsOp(32'h0000_0002);
      runOp(OpBreakB, ClassSlm, '0, RegIntr, '0, a, b, b);    // Interrupt
      ieModel = 1'b0;
      compareAllFlags();
      runOp(OpReturn, ClassSlm, '0, '0, 5'd1, a, b, a);       // RTID
      ieModel = 1'b1;
      compareAllFlags();
      mfsOp();
   endtask

   // Pipeline holds with ena low even for an MTS on the inputs
   task automatic stallHold();
      Word a;
      Word maExp;
      a     = randWord();
      maExp = lastEx;
      runOp(6'o46, ClassSlm, '0, '0, '0, randWord(), a, a);
      ena       = 1'b0;
      opcode    = OpMove;
      imm       = 16'h4000;
      opA       = 32'h0000_000F;
      waitEdges(3);
      checkWord("resEx", resEx, lastEx);
      checkWord("resMa", resMa, maExp);
      compareAllFlags();
      runOp(6'o40, ClassSlm, '0, '0, '0, 32'h0, a, a);
   endtask

   initial begin
      lfsr      = 32'd99636;
      rst       = 1'b1;
      ena       = 1'b0;
      pha       = 1'b0;
      opcode    = '0;
      unitClass = ClassAdd;
      imm       = '0;
      ra        = '0;
      rd        = '0;
      opA       = '0;
      opB       = '0;
      carryModel[0] = 1'b0;
      carryModel[1] = 1'b0;
      ieModel   = 1'b0;
      bipModel  = 1'b0;
      beModel   = 1'b0;
      lastEx    = '0;
      waitEdges(8);
      rst = 1'b0;
      checkWord("resEx", resEx, '0);
      compareAllFlags();
      adderSequence();
      logicAndShifts();
      barrelSweep();
      mixedSignCompare();
      carryPerPhase();
      flagEvents();
      stallHold();
      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- all.f
source/execPkg.sv
source/execOpIf.sv
source/arithUnit.sv
source/statusRegs.sv
source/resultStage.sv
source/execUnit.sv
bench/execTb.sv
